//--- Bender.yml
package:
  name: mem_sys

sources:
  - mem_sys_pkg.sv
  - axi_sram.sv
  - axi_arbiter.sv
  - fetch_port.sv
  - lsu_port.sv
  - mem_sys.sv
  - target: test
    files:
      - mem_sys_tb.sv

//--- axi_arbiter.sv
`timescale 1ns/1ps

module axi_arbiter (
    input  logic                            clk,
    input  logic                            rst,

    // master 0
    input  logic                            m0_arvalid, m0_awvalid, m0_wvalid,
    output logic                            m0_arready, m0_awready, m0_wready,
    input  logic [mem_sys_pkg::ADDR_W-1:0]  m0_araddr, m0_awaddr,
    input  logic [mem_sys_pkg::ID_W-1:0]    m0_arid, m0_awid,
    input  logic [mem_sys_pkg::DATA_W-1:0]  m0_wdata,
    input  logic [mem_sys_pkg::STRB_W-1:0]  m0_wstrb,
    output logic                            m0_rvalid, m0_bvalid,
    input  logic                            m0_rready, m0_bready,
    output logic [mem_sys_pkg::DATA_W-1:0]  m0_rdata,
    output logic [1:0]                      m0_rresp, m0_bresp,
    output logic [mem_sys_pkg::ID_W-1:0]    m0_rid, m0_bid,

    // master 1
    input  logic                            m1_arvalid, m1_awvalid, m1_wvalid,
    output logic                            m1_arready, m1_awready, m1_wready,
    input  logic [mem_sys_pkg::ADDR_W-1:0]  m1_araddr, m1_awaddr,
    input  logic [mem_sys_pkg::ID_W-1:0]    m1_arid, m1_awid,
    input  logic [mem_sys_pkg::DATA_W-1:0]  m1_wdata,
    input  logic [mem_sys_pkg::STRB_W-1:0]  m1_wstrb,
    output logic                            m1_rvalid, m1_bvalid,
    input  logic                            m1_rready, m1_bready,
    output logic [mem_sys_pkg::DATA_W-1:0]  m1_rdata,
    output logic [1:0]                      m1_rresp, m1_bresp,
    output logic [mem_sys_pkg::ID_W-1:0]    m1_rid, m1_bid,

    // slave
    output logic                            s_arvalid, s_awvalid, s_wvalid,
    input  logic                            s_arready, s_awready, s_wready,
    output logic [mem_sys_pkg::ADDR_W-1:0]  s_araddr, s_awaddr,
    output logic [mem_sys_pkg::ID_W-1:0]    s_arid, s_awid,
    output logic [mem_sys_pkg::DATA_W-1:0]  s_wdata,
    output logic [mem_sys_pkg::STRB_W-1:0]  s_wstrb,
    input  logic                            s_rvalid, s_bvalid,
    output logic                            s_rready, s_bready,
    input  logic [mem_sys_pkg::DATA_W-1:0]  s_rdata,
    input  logic [1:0]                      s_rresp, s_bresp,
    input  logic [mem_sys_pkg::ID_W-1:0]    s_rid, s_bid
);

    logic locked;  // grant held until the response
    logic gnt;     // 0 = m0, 1 = m1
    logic last;
    logic req0;
    logic req1;
    logic sel;
    logic r_m1;
    logic b_m1;

    assign req0 = m0_arvalid || m0_awvalid;
    assign req1 = m1_arvalid || m1_awvalid;

    always_comb begin
        if (locked)
            sel = gnt;
        else if (req0 && req1)
            sel = !last;  // tie goes to the other one
        else
            sel = req1;
    end

    assign s_arvalid = sel ? m1_arvalid : m0_arvalid;
    assign s_araddr  = sel ? m1_araddr  : m0_araddr;
    assign s_arid    = sel ? m1_arid    : m0_arid;
    assign s_awvalid = sel ? m1_awvalid : m0_awvalid;
    assign s_awaddr  = sel ? m1_awaddr  : m0_awaddr;
    assign s_awid    = sel ? m1_awid    : m0_awid;
    assign s_wvalid  = sel ? m1_wvalid  : m0_wvalid;
    assign s_wdata   = sel ? m1_wdata   : m0_wdata;
    assign s_wstrb   = sel ? m1_wstrb   : m0_wstrb;

    assign m0_arready = !sel && s_arready;
    assign m0_awready = !sel && s_awready;
    assign m0_wready  = !sel && s_wready;
    assign m1_arready = sel && s_arready;
    assign m1_awready = sel && s_awready;
    assign m1_wready  = sel && s_wready;

    // responses follow their id
    assign r_m1 = s_rid == mem_sys_pkg::ID_LSU;
    assign b_m1 = s_bid == mem_sys_pkg::ID_LSU;

    assign m0_rvalid = s_rvalid && s_rid == mem_sys_pkg::ID_FETCH;
    assign m1_rvalid = s_rvalid && r_m1;
    assign s_rready  = r_m1 ? m1_rready : m0_rready;
    assign m0_bvalid = s_bvalid && s_bid == mem_sys_pkg::ID_FETCH;
    assign m1_bvalid = s_bvalid && b_m1;
    assign s_bready  = b_m1 ? m1_bready : m0_bready;

    assign m0_rdata = s_rdata;
    assign m1_rdata = s_rdata;
    assign m0_rresp = s_rresp;
    assign m1_rresp = s_rresp;
    assign m0_rid   = s_rid;
    assign m1_rid   = s_rid;
    assign m0_bresp = s_bresp;
    assign m1_bresp = s_bresp;
    assign m0_bid   = s_bid;
    assign m1_bid   = s_bid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            locked <= 1'b0;
            gnt    <= 1'b0;
            last   <= 1'b1;  // fetch wins the first tie
        end else if (!locked) begin
            if ((s_arvalid && s_arready) || (s_awvalid && s_awready)) begin
                locked <= 1'b1;
                gnt    <= sel;
                last   <= sel;
            end
        end else if ((s_rvalid && s_rready) || (s_bvalid && s_bready)) begin
            locked <= 1'b0;
        end
    end

endmodule

//--- axi_sram.sv
`timescale 1ns/1ps

module axi_sram (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            arvalid,
    output logic                            arready,
    input  logic [mem_sys_pkg::ADDR_W-1:0]  araddr,
    input  logic [mem_sys_pkg::ID_W-1:0]    arid,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [mem_sys_pkg::DATA_W-1:0]  rdata,
    output logic [1:0]                      rresp,
    output logic [mem_sys_pkg::ID_W-1:0]    rid,

    input  logic                            awvalid,
    output logic                            awready,
    input  logic [mem_sys_pkg::ADDR_W-1:0]  awaddr,
    input  logic [mem_sys_pkg::ID_W-1:0]    awid,
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [mem_sys_pkg::DATA_W-1:0]  wdata,
    input  logic [mem_sys_pkg::STRB_W-1:0]  wstrb,
    output logic                            bvalid,
    input  logic                            bready,
    output logic [1:0]                      bresp,
    output logic [mem_sys_pkg::ID_W-1:0]    bid
);

    mem_sys_pkg::mem_word_t mem [mem_sys_pkg::MEM_WORDS];

    logic                               busy;  // response pending
    logic [mem_sys_pkg::ADDR_W-1:0]     roff;
    logic [mem_sys_pkg::ADDR_W-1:0]     woff;
    logic                               rin;
    logic                               win;
    logic [mem_sys_pkg::MEM_IDX_W-1:0]  ridx;
    logic [mem_sys_pkg::MEM_IDX_W-1:0]  widx;
    logic                               rd_hs;
    logic                               wr_hs;
    mem_sys_pkg::mem_word_t             wd;

    // offsets below the base wrap high and fall out of the window
    assign roff = araddr - mem_sys_pkg::MEM_BASE;
    assign woff = awaddr - mem_sys_pkg::MEM_BASE;
    assign rin  = roff < mem_sys_pkg::MEM_WORDS * 4;
    assign win  = woff < mem_sys_pkg::MEM_WORDS * 4;
    assign ridx = roff[mem_sys_pkg::MEM_IDX_W+1:2];
    assign widx = woff[mem_sys_pkg::MEM_IDX_W+1:2];
    assign wd.w = wdata;

    assign arready = !busy;
    assign awready = !busy && !arvalid && awvalid && wvalid;  // reads go first
    assign wready  = awready;

    assign rd_hs = arvalid && arready;
    assign wr_hs = awvalid && awready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else if (busy) begin
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                busy   <= 1'b0;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                busy   <= 1'b0;
            end
        end else if (rd_hs) begin
            busy   <= 1'b1;
            rvalid <= 1'b1;
        end else if (wr_hs) begin
            busy   <= 1'b1;
            bvalid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata <= rin ? mem[ridx].w : '0;
            rresp <= rin ? mem_sys_pkg::RESP_OKAY : mem_sys_pkg::RESP_SLVERR;
            rid   <= arid;
        end
        if (wr_hs) begin
            bresp <= win ? mem_sys_pkg::RESP_OKAY : mem_sys_pkg::RESP_SLVERR;
            bid   <= awid;
            for (int i = 0; i < mem_sys_pkg::STRB_W; i++) begin
                if (win && wstrb[i])
                    mem[widx].b[i] <= wd.b[i];
            end
        end
    end

endmodule

//--- fetch_port.sv
`timescale 1ns/1ps

module fetch_port (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            fetch_req,
    input  logic [mem_sys_pkg::ADDR_W-1:0]  fetch_addr,
    output logic                            fetch_busy,
    output logic                            fetch_done,
    output logic [mem_sys_pkg::DATA_W-1:0]  fetch_inst,
    output logic                            fetch_err,

    output logic                            arvalid,
    input  logic                            arready,
    output logic [mem_sys_pkg::ADDR_W-1:0]  araddr,
    output logic [mem_sys_pkg::ID_W-1:0]    arid,
    input  logic                            rvalid,
    output logic                            rready,
    input  logic [mem_sys_pkg::DATA_W-1:0]  rdata,
    input  logic [1:0]                      rresp,
    input  logic [mem_sys_pkg::ID_W-1:0]    rid
);

    logic start;
    logic r_hs;

    assign start  = fetch_req && !fetch_busy;
    assign r_hs   = rvalid && rready;
    assign arid   = mem_sys_pkg::ID_FETCH;
    assign rready = fetch_busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_busy <= 1'b0;
            fetch_done <= 1'b0;
            arvalid    <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            if (start) begin
                fetch_busy <= 1'b1;
                arvalid    <= 1'b1;
            end
            if (arvalid && arready)
                arvalid <= 1'b0;
            if (r_hs) begin
                fetch_busy <= 1'b0;
                fetch_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            araddr <= fetch_addr;
        if (r_hs) begin
            fetch_inst <= rdata;
            // a foreign id counts as a failed fetch
            fetch_err  <= rresp != mem_sys_pkg::RESP_OKAY || rid != mem_sys_pkg::ID_FETCH;
        end
    end

endmodule

//--- lsu_port.sv
`timescale 1ns/1ps

module lsu_port (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            lsu_req,
    input  logic                            lsu_we,
    input  logic [mem_sys_pkg::ADDR_W-1:0]  lsu_addr,
    input  logic [1:0]                      lsu_size,
    input  logic                            lsu_unsigned,
    input  logic [mem_sys_pkg::DATA_W-1:0]  lsu_wdata,
    output logic                            lsu_busy,
    output logic                            lsu_done,
    output logic [mem_sys_pkg::DATA_W-1:0]  lsu_rdata,
    output logic                            lsu_err,

    output logic                            arvalid,
    input  logic                            arready,
    output logic [mem_sys_pkg::ADDR_W-1:0]  araddr,
    output logic [mem_sys_pkg::ID_W-1:0]    arid,
    input  logic                            rvalid,
    output logic                            rready,
    input  logic [mem_sys_pkg::DATA_W-1:0]  rdata,
    input  logic [1:0]                      rresp,
    input  logic [mem_sys_pkg::ID_W-1:0]    rid,

    output logic                            awvalid,
    input  logic                            awready,
    output logic [mem_sys_pkg::ADDR_W-1:0]  awaddr,
    output logic [mem_sys_pkg::ID_W-1:0]    awid,
    output logic                            wvalid,
    input  logic                            wready,
    output logic [mem_sys_pkg::DATA_W-1:0]  wdata,
    output logic [mem_sys_pkg::STRB_W-1:0]  wstrb,
    input  logic                            bvalid,
    output logic                            bready,
    input  logic [1:0]                      bresp,
    input  logic [mem_sys_pkg::ID_W-1:0]    bid
);

    logic                               start;
    logic                               misalign;
    logic                               r_hs;
    logic                               b_hs;
    logic [mem_sys_pkg::ADDR_W-1:0]     addr_q;
    logic [1:0]                         size_q;
    logic                               uns_q;
    logic [mem_sys_pkg::DATA_W-1:0]     wdata_q;
    mem_sys_pkg::mem_word_t             wd;
    mem_sys_pkg::mem_word_t             rw;
    logic [7:0]                         lane_b;
    logic [15:0]                        lane_h;
    logic [mem_sys_pkg::DATA_W-1:0]     ld;

    assign start    = lsu_req && !lsu_busy;
    assign misalign = (lsu_size == mem_sys_pkg::SIZE_H && lsu_addr[0]) ||
                      (lsu_size == mem_sys_pkg::SIZE_W && lsu_addr[1:0] != 2'b00);
    assign r_hs     = rvalid && rready;
    assign b_hs     = bvalid && bready;

    assign araddr = addr_q;
    assign awaddr = addr_q;
    assign arid   = mem_sys_pkg::ID_LSU;
    assign awid   = mem_sys_pkg::ID_LSU;
    assign wvalid = awvalid;  // aw and w go out together
    assign rready = lsu_busy;
    assign bready = lsu_busy;
    assign wdata  = wd.w;

    // store lanes
    always_comb begin
        wd.w  = wdata_q;
        wstrb = 4'b1111;
        case (size_q)
            mem_sys_pkg::SIZE_B: begin
                for (int i = 0; i < mem_sys_pkg::STRB_W; i++)
                    wd.b[i] = wdata_q[7:0];
                wstrb = 4'b0001 << addr_q[1:0];
            end
            mem_sys_pkg::SIZE_H: begin
                wd.h[0] = wdata_q[15:0];
                wd.h[1] = wdata_q[15:0];
                wstrb   = 4'b0011 << addr_q[1:0];
            end
            default: ;
        endcase
    end

    // load lane pick and extend
    assign rw.w   = rdata;
    assign lane_b = rw.b[addr_q[1:0]];
    assign lane_h = rw.h[addr_q[1]];

    always_comb begin
        case (size_q)
            mem_sys_pkg::SIZE_B: ld = {{24{lane_b[7] && !uns_q}}, lane_b};
            mem_sys_pkg::SIZE_H: ld = {{16{lane_h[15] && !uns_q}}, lane_h};
            default:             ld = rw.w;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lsu_busy <= 1'b0;
            lsu_done <= 1'b0;
            arvalid  <= 1'b0;
            awvalid  <= 1'b0;
        end else begin
            lsu_done <= 1'b0;
            if (start && misalign) begin
                lsu_done <= 1'b1;  // no bus access
            end else if (start) begin
                lsu_busy <= 1'b1;
                arvalid  <= !lsu_we;
                awvalid  <= lsu_we;
            end
            if (arvalid && arready)
                arvalid <= 1'b0;
            if (awvalid && awready)
                awvalid <= 1'b0;
            if (r_hs || b_hs) begin
                lsu_busy <= 1'b0;
                lsu_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= lsu_addr;
            size_q  <= lsu_size;
            uns_q   <= lsu_unsigned;
            wdata_q <= lsu_wdata;
            if (misalign)
                lsu_err <= 1'b1;
        end
        if (r_hs) begin
            lsu_rdata <= ld;
            lsu_err   <= rresp != mem_sys_pkg::RESP_OKAY || rid != mem_sys_pkg::ID_LSU;
        end
        if (b_hs)
            lsu_err <= bresp != mem_sys_pkg::RESP_OKAY || bid != mem_sys_pkg::ID_LSU;
    end

endmodule

//--- mem_sys.f
mem_sys_pkg.sv
axi_sram.sv
axi_arbiter.sv
fetch_port.sv
lsu_port.sv
mem_sys.sv
mem_sys_tb.sv

//--- mem_sys.sv
`timescale 1ns/1ps

module mem_sys (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            fetch_req,
    input  logic [mem_sys_pkg::ADDR_W-1:0]  fetch_addr,
    output logic                            fetch_busy,
    output logic                            fetch_done,
    output logic [mem_sys_pkg::DATA_W-1:0]  fetch_inst,
    output logic                            fetch_err,

    input  logic                            lsu_req,
    input  logic                            lsu_we,
    input  logic [mem_sys_pkg::ADDR_W-1:0]  lsu_addr,
    input  logic [1:0]                      lsu_size,
    input  logic                            lsu_unsigned,
    input  logic [mem_sys_pkg::DATA_W-1:0]  lsu_wdata,
    output logic                            lsu_busy,
    output logic                            lsu_done,
    output logic [mem_sys_pkg::DATA_W-1:0]  lsu_rdata,
    output logic                            lsu_err
);

    // fetch side, read only
    logic                               m0_arvalid, m0_arready, m0_rvalid, m0_rready;
    logic [mem_sys_pkg::ADDR_W-1:0]     m0_araddr;
    logic [mem_sys_pkg::ID_W-1:0]       m0_arid, m0_rid;
    logic [mem_sys_pkg::DATA_W-1:0]     m0_rdata;
    logic [1:0]                         m0_rresp;

    // lsu side
    logic                               m1_arvalid, m1_arready, m1_rvalid, m1_rready;
    logic                               m1_awvalid, m1_awready, m1_wvalid, m1_wready;
    logic                               m1_bvalid, m1_bready;
    logic [mem_sys_pkg::ADDR_W-1:0]     m1_araddr, m1_awaddr;
    logic [mem_sys_pkg::ID_W-1:0]       m1_arid, m1_rid, m1_awid, m1_bid;
    logic [mem_sys_pkg::DATA_W-1:0]     m1_rdata, m1_wdata;
    logic [mem_sys_pkg::STRB_W-1:0]     m1_wstrb;
    logic [1:0]                         m1_rresp, m1_bresp;

    // arbiter to sram
    logic                               s_arvalid, s_arready, s_rvalid, s_rready;
    logic                               s_awvalid, s_awready, s_wvalid, s_wready;
    logic                               s_bvalid, s_bready;
    logic [mem_sys_pkg::ADDR_W-1:0]     s_araddr, s_awaddr;
    logic [mem_sys_pkg::ID_W-1:0]       s_arid, s_rid, s_awid, s_bid;
    logic [mem_sys_pkg::DATA_W-1:0]     s_rdata, s_wdata;
    logic [mem_sys_pkg::STRB_W-1:0]     s_wstrb;
    logic [1:0]                         s_rresp, s_bresp;

    fetch_port u_fetch (
        .*,
        .arvalid(m0_arvalid), .arready(m0_arready), .araddr(m0_araddr), .arid(m0_arid),
        .rvalid(m0_rvalid), .rready(m0_rready), .rdata(m0_rdata), .rresp(m0_rresp),
        .rid(m0_rid)
    );

    lsu_port u_lsu (
        .*,
        .arvalid(m1_arvalid), .arready(m1_arready), .araddr(m1_araddr), .arid(m1_arid),
        .rvalid(m1_rvalid), .rready(m1_rready), .rdata(m1_rdata), .rresp(m1_rresp),
        .rid(m1_rid),
        .awvalid(m1_awvalid), .awready(m1_awready), .awaddr(m1_awaddr), .awid(m1_awid),
        .wvalid(m1_wvalid), .wready(m1_wready), .wdata(m1_wdata), .wstrb(m1_wstrb),
        .bvalid(m1_bvalid), .bready(m1_bready), .bresp(m1_bresp), .bid(m1_bid)
    );

    // fetch never writes
    axi_arbiter u_arb (
        .*,
        .m0_awvalid(1'b0), .m0_awaddr('0), .m0_awid('0),
        .m0_wvalid(1'b0), .m0_wdata('0), .m0_wstrb('0), .m0_bready(1'b0),
        .m0_awready(), .m0_wready(), .m0_bvalid(), .m0_bresp(), .m0_bid()
    );

    axi_sram u_sram (
        .clk(clk), .rst(rst),
        .arvalid(s_arvalid), .arready(s_arready), .araddr(s_araddr), .arid(s_arid),
        .rvalid(s_rvalid), .rready(s_rready), .rdata(s_rdata), .rresp(s_rresp),
        .rid(s_rid),
        .awvalid(s_awvalid), .awready(s_awready), .awaddr(s_awaddr), .awid(s_awid),
        .wvalid(s_wvalid), .wready(s_wready), .wdata(s_wdata), .wstrb(s_wstrb),
        .bvalid(s_bvalid), .bready(s_bready), .bresp(s_bresp), .bid(s_bid)
    );

endmodule

//--- mem_sys_pkg.sv
package mem_sys_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int ID_W   = 4;

    // sram window
    localparam logic [ADDR_W-1:0] MEM_BASE  = 32'h8000_0000;
    localparam int                MEM_WORDS = 1024;  // 4 KiB
    localparam int                MEM_IDX_W = 10;

    // requester ids, responses are routed back by these
    localparam logic [ID_W-1:0] ID_FETCH = 4'd0;
    localparam logic [ID_W-1:0] ID_LSU   = 4'd1;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam logic [1:0] SIZE_B = 2'd0;
    localparam logic [1:0] SIZE_H = 2'd1;
    localparam logic [1:0] SIZE_W = 2'd2;

    // one data word, whole or split into lanes
    typedef union packed {
        logic [DATA_W-1:0]      w;
        logic [STRB_W-1:0][7:0] b;
        logic [1:0][15:0]       h;
    } mem_word_t;

endpackage

//--- mem_sys_tb.sv
`timescale 1ns/1ps

module mem_sys_tb;

    localparam int TIMEOUT_CYCLES = 20000;  // 6 tests x 300 accesses x 8 cycles plus margin
    localparam int NWORDS         = 64;
    localparam int WIN_BYTES      = mem_sys_pkg::MEM_WORDS * 4;

    logic        clk;
    logic        rst;
    logic        fetch_req;
    logic [31:0] fetch_addr;
    logic        fetch_busy;
    logic        fetch_done;
    logic [31:0] fetch_inst;
    logic        fetch_err;
    logic        lsu_req;
    logic        lsu_we;
    logic [31:0] lsu_addr;
    logic [1:0]  lsu_size;
    logic        lsu_unsigned;
    logic [31:0] lsu_wdata;
    logic        lsu_busy;
    logic        lsu_done;
    logic [31:0] lsu_rdata;
    logic        lsu_err;

    logic [7:0]  model [WIN_BYTES];  // byte image of the sram window
    logic [31:0] used [NWORDS];      // word addresses stored in the word test
    logic [31:0] lfsr;
    int          cycles;
    int          errors;
    int          test_errors;
    int          failed_tests;

    mem_sys UUT (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return v;
    endfunction

    function automatic logic [31:0] model_load(input logic [31:0] addr, input logic [1:0] size,
                                               input logic uns);
        int          off;
        logic [31:0] v;
        off = addr - mem_sys_pkg::MEM_BASE;
        case (size)
            mem_sys_pkg::SIZE_B: begin
                v[7:0]  = model[off];
                v[31:8] = uns ? 24'h0 : {24{v[7]}};
            end
            mem_sys_pkg::SIZE_H: begin
                v[15:0]  = {model[off+1], model[off]};
                v[31:16] = uns ? 16'h0 : {16{v[15]}};
            end
            default: v = {model[off+3], model[off+2], model[off+1], model[off]};
        endcase
        return v;
    endfunction

    function automatic void model_store(input logic [31:0] addr, input logic [1:0] size,
                                        input logic [31:0] data);
        int off;
        int n;
        off = addr - mem_sys_pkg::MEM_BASE;
        n   = size == mem_sys_pkg::SIZE_B ? 1 : size == mem_sys_pkg::SIZE_H ? 2 : 4;
        for (int i = 0; i < n; i++)
            model[off+i] = data[8*i +: 8];  // little endian lanes
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("[FAIL] %s expected %h got %h", name, exp, got);
        errors++;
        test_errors++;
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
            failed_tests++;
        end
        test_errors = 0;
    endtask

    task automatic lsu_access(input logic we, input logic [31:0] addr, input logic [1:0] size,
                              input logic uns, input logic [31:0] wdata);
        @(posedge clk);
        #5;
        lsu_req      = 1'b1;
        lsu_we       = we;
        lsu_addr     = addr;
        lsu_size     = size;
        lsu_unsigned = uns;
        lsu_wdata    = wdata;
        @(posedge clk);
        #5;
        lsu_req = 1'b0;
        while (!lsu_done) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic fetch_access(input logic [31:0] addr);
        @(posedge clk);
        #5;
        fetch_req  = 1'b1;
        fetch_addr = addr;
        @(posedge clk);
        #5;
        fetch_req = 1'b0;
        while (!fetch_done) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic reset_state();
        if (fetch_busy !== 1'b0) report_mismatch("fetch_busy", 0, fetch_busy);
        if (lsu_busy !== 1'b0) report_mismatch("lsu_busy", 0, lsu_busy);
        if (fetch_done !== 1'b0) report_mismatch("fetch_done", 0, fetch_done);
        if (lsu_done !== 1'b0) report_mismatch("lsu_done", 0, lsu_done);
        report_test("reset state");
    endtask

    task automatic word_roundtrip();
        logic [31:0] data;
        logic [31:0] exp;
        for (int i = 0; i < NWORDS; i++) begin
            // distinct low index bits keep the words apart
            used[i] = mem_sys_pkg::MEM_BASE + (rand_bits(4) << 8) + (i << 2);
            data    = rand_bits(32);
            lsu_access(1'b1, used[i], mem_sys_pkg::SIZE_W, 1'b0, data);
            if (lsu_err !== 1'b0) report_mismatch("lsu_err", 0, lsu_err);
            model_store(used[i], mem_sys_pkg::SIZE_W, data);
        end
        for (int i = 0; i < NWORDS; i++) begin
            exp = model_load(used[i], mem_sys_pkg::SIZE_W, 1'b0);
            lsu_access(1'b0, used[i], mem_sys_pkg::SIZE_W, 1'b0, 32'h0);
            if (lsu_rdata !== exp) report_mismatch("lsu_rdata", exp, lsu_rdata);
            if (lsu_err !== 1'b0) report_mismatch("lsu_err", 0, lsu_err);
            fetch_access(used[i]);
            if (fetch_inst !== exp) report_mismatch("fetch_inst", exp, fetch_inst);
            if (fetch_err !== 1'b0) report_mismatch("fetch_err", 0, fetch_err);
        end
        report_test("word store and read back");
    endtask

    task automatic subword_lanes();
        logic        half;
        logic        uns;
        logic [1:0]  size;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        for (int i = 0; i < NWORDS; i++) begin
            half = rand_bits(1);
            size = half ? mem_sys_pkg::SIZE_H : mem_sys_pkg::SIZE_B;
            addr = used[i] + (half ? rand_bits(1) << 1 : rand_bits(2));
            data = rand_bits(32);
            lsu_access(1'b1, addr, size, 1'b0, data);
            if (lsu_err !== 1'b0) report_mismatch("lsu_err", 0, lsu_err);
            model_store(addr, size, data);
            exp = model_load(used[i], mem_sys_pkg::SIZE_W, 1'b0);
            lsu_access(1'b0, used[i], mem_sys_pkg::SIZE_W, 1'b0, 32'h0);
            if (lsu_rdata !== exp) report_mismatch("lsu_rdata", exp, lsu_rdata);
            uns = rand_bits(1);
            exp = model_load(addr, size, uns);
            lsu_access(1'b0, addr, size, uns, 32'h0);
            if (lsu_rdata !== exp) report_mismatch("lsu_rdata", exp, lsu_rdata);
            if (lsu_err !== 1'b0) report_mismatch("lsu_err", 0, lsu_err);
        end
        report_test("byte and halfword lanes");
    endtask

    task automatic out_of_window();
        int          idx;
        logic [31:0] off;
        logic [31:0] addr;
        logic [31:0] exp;
        for (int i = 0; i < 8; i++) begin
            idx  = rand_bits(6);
            off  = used[idx] - mem_sys_pkg::MEM_BASE;
            // same offset one window below or above, so aliasing would show
            addr = rand_bits(1) ? mem_sys_pkg::MEM_BASE - WIN_BYTES + off
                                : mem_sys_pkg::MEM_BASE + WIN_BYTES + off;
            lsu_access(1'b1, addr, mem_sys_pkg::SIZE_W, 1'b0, rand_bits(32));
            if (lsu_err !== 1'b1) report_mismatch("lsu_err", 1, lsu_err);
            lsu_access(1'b0, addr, mem_sys_pkg::SIZE_W, 1'b0, 32'h0);
            if (lsu_err !== 1'b1) report_mismatch("lsu_err", 1, lsu_err);
            if (lsu_rdata !== 32'h0) report_mismatch("lsu_rdata", 0, lsu_rdata);
            fetch_access(addr);
            if (fetch_err !== 1'b1) report_mismatch("fetch_err", 1, fetch_err);
            exp = model_load(used[idx], mem_sys_pkg::SIZE_W, 1'b0);
            lsu_access(1'b0, used[idx], mem_sys_pkg::SIZE_W, 1'b0, 32'h0);
            if (lsu_rdata !== exp) report_mismatch("lsu_rdata", exp, lsu_rdata);
        end
        report_test("out of window");
    endtask

    task automatic misaligned();
        int          idx;
        logic        half;
        logic [1:0]  off;
        logic [31:0] exp;
        for (int i = 0; i < 16; i++) begin
            idx  = rand_bits(6);
            half = rand_bits(1);
            off  = rand_bits(2);
            if (half)
                off[0] = 1'b1;
            else if (off == 2'd0)
                off = 2'd3;
            lsu_access(rand_bits(1), used[idx] + off,
                       half ? mem_sys_pkg::SIZE_H : mem_sys_pkg::SIZE_W, 1'b0, rand_bits(32));
            if (lsu_err !== 1'b1) report_mismatch("lsu_err", 1, lsu_err);
            exp = model_load(used[idx], mem_sys_pkg::SIZE_W, 1'b0);
            lsu_access(1'b0, used[idx], mem_sys_pkg::SIZE_W, 1'b0, 32'h0);
            if (lsu_rdata !== exp) report_mismatch("lsu_rdata", exp, lsu_rdata);
        end
        report_test("misaligned access");
    endtask

    task automatic concurrent_traffic();
        int          fidx;
        int          lidx;
        logic        we;
        logic        uns;
        logic [1:0]  size;
        logic [31:0] laddr;
        logic [31:0] data;
        logic [31:0] fexp;
        logic [31:0] lexp;
        for (int i = 0; i < 200; i++) begin
            fidx  = rand_bits(5);       // fetch stays in the lower half
            lidx  = 32 + rand_bits(5);  // lsu in the upper half
            we    = rand_bits(1);
            size  = rand_bits(1) ? mem_sys_pkg::SIZE_W : mem_sys_pkg::SIZE_B;
            laddr = used[lidx] + (size == mem_sys_pkg::SIZE_B ? rand_bits(2) : 0);
            uns   = rand_bits(1);
            data  = rand_bits(32);
            fexp  = model_load(used[fidx], mem_sys_pkg::SIZE_W, 1'b0);
            lexp  = model_load(laddr, size, uns);
            fork
                fetch_access(used[fidx]);
                lsu_access(we, laddr, size, uns, data);
            join
            if (fetch_inst !== fexp) report_mismatch("fetch_inst", fexp, fetch_inst);
            if (fetch_err !== 1'b0) report_mismatch("fetch_err", 0, fetch_err);
            if (lsu_err !== 1'b0) report_mismatch("lsu_err", 0, lsu_err);
            if (we)
                model_store(laddr, size, data);
            else if (lsu_rdata !== lexp)
                report_mismatch("lsu_rdata", lexp, lsu_rdata);
        end
        report_test("concurrent traffic");
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        fetch_req    = 1'b0;
        fetch_addr   = 32'h0;
        lsu_req      = 1'b0;
        lsu_we       = 1'b0;
        lsu_addr     = 32'h0;
        lsu_size     = 2'd0;
        lsu_unsigned = 1'b0;
        lsu_wdata    = 32'h0;
        lfsr         = 32'hd2df;
        cycles       = 0;
        errors       = 0;
        test_errors  = 0;
        failed_tests = 0;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;
        reset_state();
        word_roundtrip();
        subword_lanes();
        out_of_window();
        misaligned();
        concurrent_traffic();
        $display("tests: 6, failed: %0d, errors: %0d", failed_tests, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
